// File: sd_host.f
logic/sd_host_pkg.sv
logic/sd_host_regs.sv
logic/sd_cmd_phy.sv
logic/sd_dat_rx.sv
logic/sd_xfer_ctrl.sv
logic/sd_host.sv
bench/sd_card_model.sv
bench/sd_host_tb.sv

// File: bench/sd_host_tb.sv
//////////////////////////////
// SD host testbench, read path only
// Checks are concurrent assertions
// Inputs change on the falling edge
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_host_tb import sd_host_pkg::*; ();

   localparam logic [31:0] RESP_XOR = 32'hC3A5_5A3C;
   // Writes, frame, longest delay, response and idle slack
   localparam int CMD_MARGIN  = 220;
   localparam int BLK_EXTRA   = DAT_CRC_NIBBLES + 12;
   // Six commands, 144 bytes over 9 streamed blocks
   localparam int CYCLE_LIMIT = 6 * CMD_MARGIN + 2 * 144 + 9 * BLK_EXTRA;

   logic         clk;
   logic         arst_n;
   logic         req;
   logic         reg_wr_en;
   reg_addr_t    reg_address;
   reg_data_t    reg_wr_data;
   logic         cmd_in;
   logic [3:0]   dat_in;
   logic         cmd_out;
   logic         cmd_oe;
   logic         resp_valid;
   resp_t        resp;
   logic         word_valid;
   dat_word_t    word;
   logic         xfer_done;
   xfer_status_t status;

   // Card setup
   int unsigned  resp_delay;
   logic [1:0]   resp_mode;
   int unsigned  card_blks;
   int unsigned  blk_bytes;
   logic         card_busy;

   // Expected results of the running test
   logic [47:0]  exp_frame;
   cmd_arg_t     exp_arg;
   logic [2:0]   exp_flags;
   xfer_status_t exp_status;
   int           exp_words;

   int tx_bit     = 0;
   int words_seen = 0;
   int words_base = 0;
   int errors     = 0;
   int tests      = 0;
   int cycles     = 0;

   sd_host u_sd_host (
      .clk         (clk),
      .arst_n      (arst_n),
      .req         (req),
      .reg_wr_en   (reg_wr_en),
      .reg_address (reg_address),
      .reg_wr_data (reg_wr_data),
      .cmd_in      (cmd_in),
      .dat_in      (dat_in),
      .cmd_out     (cmd_out),
      .cmd_oe      (cmd_oe),
      .resp_valid  (resp_valid),
      .resp        (resp),
      .word_valid  (word_valid),
      .word        (word),
      .xfer_done   (xfer_done),
      .status      (status)
   );

   sd_card_model #(.RESP_XOR(RESP_XOR)) u_card (
      .clk        (clk),
      .cmd_out    (cmd_out),
      .cmd_oe     (cmd_oe),
      .resp_delay (resp_delay),
      .resp_mode  (resp_mode),
      .n_blocks   (card_blks),
      .blk_bytes  (blk_bytes),
      .cmd_in     (cmd_in),
      .dat_in     (dat_in),
      .busy       (card_busy)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Frame bit position and word count
   always_ff @(posedge clk) begin
      tx_bit <= cmd_oe ? tx_bit + 1 : 0;
      if (word_valid) begin
         words_seen <= words_seen + 1;
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Run stopped, no completion within %0d cycles", CYCLE_LIMIT);
         $display("Test failed");
         $finish;
      end
   end

   // CRC7 as remainder of msg * x^7 over x^7 + x^3 + 1
   function automatic crc7_t crc7_of(input logic [39:0] msg);
      logic [46:0] rem;
      rem = {msg, 7'b0};
      for (int i = 46; i >= 7; i--) begin
         if (rem[i]) begin
            rem[i -: 8] = rem[i -: 8] ^ 8'h89;
         end
      end
      return rem[6:0];
   endfunction

   function automatic logic [3:0] nib_at(input int k);
      return 4'(k) ^ 4'(k >> 4) ^ 4'(k >> 8);
   endfunction

   // Word w of a transfer, first nibble on top
   function automatic dat_word_t word_at(input int w);
      dat_word_t v;
      v = '0;
      for (int i = 0; i < 8; i++) begin
         v = {v[27:0], nib_at(8 * w + i)};
      end
      return v;
   endfunction

   //////////////////////////////
   // Checks
   //////////////////////////////
   a_reset_idle: assert property (@(posedge clk)
      !arst_n |-> cmd_out && !cmd_oe && !resp_valid && !word_valid && !xfer_done)
      else begin
         errors++;
         $display("CHECK FAILED reset cmd_out=%h cmd_oe=%h resp_valid=%h word_valid=%h xfer_done=%h",
            $sampled(cmd_out), $sampled(cmd_oe), $sampled(resp_valid),
            $sampled(word_valid), $sampled(xfer_done));
      end

   a_frame_bit: assert property (@(posedge clk) disable iff (!arst_n)
      cmd_oe |-> cmd_out == exp_frame[47 - tx_bit])
      else begin
         errors++;
         $display("CHECK FAILED cmd_out bit %0d got %h exp %h", $sampled(tx_bit),
            $sampled(cmd_out), exp_frame[47 - $sampled(tx_bit)]);
      end

   a_frame_len: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(cmd_oe) |-> tx_bit == CMD_FRAME_BITS)
      else begin
         errors++;
         $display("CHECK FAILED cmd_oe length got %h exp %h", $sampled(tx_bit), CMD_FRAME_BITS);
      end

   a_resp_flags: assert property (@(posedge clk) disable iff (!arst_n)
      resp_valid |-> {resp.crc_ok, resp.end_ok, resp.timeout} == exp_flags)
      else begin
         errors++;
         $display("CHECK FAILED resp flags got %h exp %h",
            {$sampled(resp.crc_ok), $sampled(resp.end_ok), $sampled(resp.timeout)}, exp_flags);
      end

   a_resp_arg: assert property (@(posedge clk) disable iff (!arst_n)
      resp_valid && exp_flags == 3'b110 |-> resp.arg == exp_arg)
      else begin
         errors++;
         $display("CHECK FAILED resp.arg got %h exp %h", $sampled(resp.arg), exp_arg);
      end

   a_word_count: assert property (@(posedge clk) disable iff (!arst_n)
      word_valid |-> words_seen - words_base < exp_words)
      else begin
         errors++;
         $display("Unexpected word_valid, %0d words already seen of %0d expected",
            $sampled(words_seen) - $sampled(words_base), exp_words);
      end

   a_word_data: assert property (@(posedge clk) disable iff (!arst_n)
      word_valid && words_seen - words_base < exp_words |->
         word == word_at(words_seen - words_base))
      else begin
         errors++;
         $display("CHECK FAILED word got %h exp %h", $sampled(word),
            word_at($sampled(words_seen) - $sampled(words_base)));
      end

   a_done_status: assert property (@(posedge clk) disable iff (!arst_n)
      xfer_done |-> status == exp_status)
      else begin
         errors++;
         $display("CHECK FAILED status got %h exp %h", $sampled(status), exp_status);
      end

   a_done_words: assert property (@(posedge clk) disable iff (!arst_n)
      xfer_done |-> words_seen - words_base == exp_words)
      else begin
         errors++;
         $display("CHECK FAILED word count got %h exp %h",
            $sampled(words_seen) - $sampled(words_base), exp_words);
      end

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   task automatic write_reg(input reg_addr_t addr, input logic [15:0] data);
      @(negedge clk);
      req         = 1'b1;
      reg_wr_en   = 1'b1;
      reg_address = addr;
      reg_wr_data = {16'h0, data};
      @(negedge clk);
      req       = 1'b0;
      reg_wr_en = 1'b0;
   endtask

   // One command, its response and any data phase
   task automatic run_cmd(input string name, input cmd_idx_t idx, input logic dat,
      input logic [15:0] mode, input int bytes, input int cnt, input logic [1:0] rmode,
      input int stream_blks, input int exp_blks);
      cmd_arg_t arg;
      int       err0;
      arg  = $urandom;
      err0 = errors;
      while (card_busy) @(negedge clk);
      @(negedge clk);
      resp_mode  = rmode;
      resp_delay = $urandom_range(40, 0);
      card_blks  = stream_blks;
      blk_bytes  = bytes;
      exp_frame  = {2'b01, idx, arg, crc7_of({2'b01, idx, arg}), 1'b1};
      exp_arg    = arg ^ RESP_XOR;
      exp_flags  = (rmode == 2'd0) ? 3'b110 : (rmode == 2'd1) ? 3'b010 : 3'b001;
      exp_status.resp_err    = (rmode == 2'd1);
      exp_status.timeout     = (rmode == 2'd2);
      exp_status.blocks_done = (rmode == 2'd0 && dat) ? 16'(exp_blks) : '0;
      exp_words  = (rmode == 2'd0 && dat) ? exp_blks * bytes / 4 : 0;
      words_base = words_seen;
      write_reg(ADDR_BLK_SIZE, 16'(bytes));
      write_reg(ADDR_BLK_CNT, 16'(cnt));
      write_reg(ADDR_ARG_LO, arg[15:0]);
      write_reg(ADDR_ARG_HI, arg[31:16]);
      write_reg(ADDR_XFER_MODE, mode);
      // Index in 13:8, data present in bit 5
      write_reg(ADDR_CMD, {2'b00, idx, 2'b00, dat, 5'b0});
      @(negedge clk);
      while (!xfer_done) @(negedge clk);
      repeat (4) @(negedge clk);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "errors");
   endtask

   initial begin
      void'($urandom(89));
      arst_n      = 1'b1;
      req         = 1'b0;
      reg_wr_en   = 1'b0;
      reg_address = '0;
      reg_wr_data = '0;
      resp_mode   = 2'd0;
      resp_delay  = 0;
      card_blks   = 0;
      blk_bytes   = 8;
      exp_frame   = '0;
      exp_arg     = '0;
      exp_flags   = 3'b000;
      exp_status  = '0;
      exp_words   = 0;
      #10 arst_n = 1'b0;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      tests++;
      $display("test %0d reset values: %s", tests, (errors == 0) ? "ok" : "errors");
      // Mode bits: 5 multi, 4 read, 1 count enable
      run_cmd("status command", 6'd13, 1'b0, 16'h0000, 4, 0, 2'd0, 0, 0);
      run_cmd("bad response crc", 6'd17, 1'b1, 16'h0010, 8, 1, 2'd1, 1, 0);
      run_cmd("no response", 6'd17, 1'b1, 16'h0010, 8, 1, 2'd2, 0, 0);
      run_cmd("multi block counted", 6'd18, 1'b1, 16'h0032, 16, 3, 2'd0, 3, 3);
      run_cmd("single block", 6'd17, 1'b1, 16'h0012, 8, 4, 2'd0, 3, 1);
      run_cmd("multi block uncounted", 6'd18, 1'b1, 16'h0030, 32, 2, 2'd0, 2, 2);
      while (card_busy) @(negedge clk);
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/sd_card_model.sv
//////////////////////////////
// Behavioral SD card, read commands only
// Inputs must be set before the command frame starts
// CMD17 and CMD18 stream n_blocks blocks of counter data
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_card_model import sd_host_pkg::*; #(
   parameter logic [31:0] RESP_XOR = 32'h5A5A_0FF0
) (
   input  logic        clk,
   input  logic        cmd_out,
   input  logic        cmd_oe,
   input  int unsigned resp_delay,
   // 0 good, 1 bad CRC, 2 silent
   input  logic [1:0]  resp_mode,
   input  int unsigned n_blocks,
   input  int unsigned blk_bytes,
   output logic        cmd_in,
   output logic [3:0]  dat_in,
   output logic        busy
);

   logic [47:0] frame;
   int          nbits;

   // Long division by x^7 + x^3 + 1
   function automatic logic [6:0] crc7_of(input logic [39:0] msg);
      logic [46:0] rem;
      rem = {msg, 7'b0};
      for (int i = 46; i >= 7; i--) begin
         if (rem[i]) begin
            rem[i -: 8] = rem[i -: 8] ^ 8'h89;
         end
      end
      return rem[6:0];
   endfunction

   // Data nibble k of a transfer
   function automatic logic [3:0] nib_at(input int k);
      return 4'(k) ^ 4'(k >> 4) ^ 4'(k >> 8);
   endfunction

   task automatic send_response(input logic [5:0] idx, input logic [31:0] arg);
      logic [39:0] body;
      logic [47:0] rsp;
      body = {2'b00, idx, arg ^ RESP_XOR};
      // Flip the CRC LSB in bad CRC mode
      rsp  = {body, crc7_of(body) ^ {6'd0, resp_mode == 2'd1}, 1'b1};
      repeat (resp_delay) @(negedge clk);
      for (int i = 47; i >= 0; i--) begin
         cmd_in = rsp[i];
         @(negedge clk);
      end
      cmd_in = 1'b1;
   endtask

   task automatic send_blocks();
      int k;
      k = 0;
      repeat (6) @(negedge clk);
      for (int b = 0; b < n_blocks; b++) begin
         // Start nibble
         dat_in = 4'h0;
         @(negedge clk);
         for (int n = 0; n < 2 * blk_bytes; n++) begin
            dat_in = nib_at(k);
            k++;
            @(negedge clk);
         end
         // Dummy CRC16 nibbles
         repeat (DAT_CRC_NIBBLES) begin
            dat_in = 4'hA;
            @(negedge clk);
         end
         // End nibble and idle gap
         dat_in = 4'hF;
         repeat (5) @(negedge clk);
      end
   endtask

   initial begin
      cmd_in = 1'b1;
      dat_in = 4'hF;
      busy   = 1'b0;
      nbits  = 0;
      frame  = '0;
      forever begin
         @(negedge clk);
         if (cmd_oe === 1'b1) begin
            frame = {frame[46:0], cmd_out};
            nbits++;
         end else if (nbits == CMD_FRAME_BITS) begin
            // Frame just ended, line released
            nbits = 0;
            busy  = 1'b1;
            if (resp_mode != 2'd2) begin
               send_response(frame[45:40], frame[39:8]);
               if (frame[45:40] == 6'd17 || frame[45:40] == 6'd18) begin
                  send_blocks();
               end
            end
            busy = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/sd_host.sv
//////////////////////////////
// SD host top, 4-bit read only
// Words must be taken on word_valid
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_host import sd_host_pkg::*; (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         req,
   input  logic         reg_wr_en,
   input  reg_addr_t    reg_address,
   input  reg_data_t    reg_wr_data,
   input  logic         cmd_in,
   input  logic [3:0]   dat_in,
   output logic         cmd_out,
   output logic         cmd_oe,
   output logic         resp_valid,
   output resp_t        resp,
   output logic         word_valid,
   output dat_word_t    word,
   output logic         xfer_done,
   output xfer_status_t status
);

   xfer_cfg_t cfg;
   logic      cmd_start;
   logic      phy_start;
   logic      dat_arm;
   logic      dat_more;
   logic      blk_done;

   sd_host_regs u_regs (
      .clk         (clk),
      .arst_n      (arst_n),
      .req         (req),
      .reg_wr_en   (reg_wr_en),
      .reg_address (reg_address),
      .reg_wr_data (reg_wr_data),
      .cfg         (cfg),
      .cmd_start   (cmd_start)
   );

   sd_cmd_phy u_cmd_phy (
      .clk        (clk),
      .arst_n     (arst_n),
      .phy_start  (phy_start),
      .cmd_idx    (cfg.cmd_idx),
      .arg        (cfg.arg),
      .cmd_in     (cmd_in),
      .cmd_out    (cmd_out),
      .cmd_oe     (cmd_oe),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

   sd_dat_rx u_dat_rx (
      .clk        (clk),
      .arst_n     (arst_n),
      .dat_arm    (dat_arm),
      .dat_more   (dat_more),
      .blk_size   (cfg.blk_size),
      .dat_in     (dat_in),
      .word_valid (word_valid),
      .word       (word),
      .blk_done   (blk_done)
   );

   // Joins response and block results
   sd_xfer_ctrl u_xfer_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .cmd_start  (cmd_start),
      .cfg        (cfg),
      .resp_valid (resp_valid),
      .resp       (resp),
      .blk_done   (blk_done),
      .phy_start  (phy_start),
      .dat_arm    (dat_arm),
      .dat_more   (dat_more),
      .xfer_done  (xfer_done),
      .status     (status)
   );

endmodule

`default_nettype wire

// File: logic/sd_xfer_ctrl.sv
//////////////////////////////
// Command and data phase sequencer
// No stop command, multi-block always ends after blk_cnt
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_xfer_ctrl import sd_host_pkg::*; (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         cmd_start,
   input  xfer_cfg_t    cfg,
   input  logic         resp_valid,
   input  resp_t        resp,
   input  logic         blk_done,
   output logic         phy_start,
   output logic         dat_arm,
   output logic         dat_more,
   output logic         xfer_done,
   output xfer_status_t status
);

   ctrl_state_e state;
   blk_cnt_t    target;
   blk_cnt_t    next_cnt;
   logic        last_blk;
   logic        resp_good;

   // Single block, or blk_cnt blocks with or without blk_cnt_en
   assign target    = (cfg.multi_blk && cfg.blk_cnt != '0) ? cfg.blk_cnt : blk_cnt_t'(1);
   assign next_cnt  = status.blocks_done + 1'b1;
   assign last_blk  = (next_cnt >= target);
   assign resp_good = resp.crc_ok && resp.end_ok && !resp.timeout;
   // Receiver rearms on this level at block end
   assign dat_more  = (state == CTRL_DATA) && !last_blk;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= CTRL_IDLE;
         phy_start <= 1'b0;
         dat_arm   <= 1'b0;
         xfer_done <= 1'b0;
         status    <= '0;
      end else begin
         phy_start <= 1'b0;
         dat_arm   <= 1'b0;
         xfer_done <= 1'b0;
         case (state)
            CTRL_IDLE: begin
               // Starts while busy are dropped
               if (cmd_start) begin
                  phy_start <= 1'b1;
                  status    <= '0;
                  state     <= CTRL_CMD;
               end
            end
            CTRL_CMD: begin
               if (resp_valid) begin
                  status.timeout  <= resp.timeout;
                  status.resp_err <= !resp.timeout && !(resp.crc_ok && resp.end_ok);
                  if (resp_good && cfg.data_present && cfg.read_dir) begin
                     dat_arm <= 1'b1;
                     state   <= CTRL_DATA;
                  end else begin
                     xfer_done <= 1'b1;
                     state     <= CTRL_IDLE;
                  end
               end
            end
            CTRL_DATA: begin
               if (blk_done) begin
                  status.blocks_done <= next_cnt;
                  if (last_blk) begin
                     xfer_done <= 1'b1;
                     state     <= CTRL_IDLE;
                  end
               end
            end
            default: state <= CTRL_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/sd_dat_rx.sv
//////////////////////////////
// 4-bit DAT block receiver
// CRC16 nibbles skipped, not checked
// No back-pressure on word output
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_dat_rx import sd_host_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       dat_arm,
   input  logic       dat_more,
   input  blk_size_t  blk_size,
   input  logic [3:0] dat_in,
   output logic       word_valid,
   output dat_word_t  word,
   output logic       blk_done
);

   dat_state_e  state;
   // Nibble index inside the block
   logic [12:0] nib_cnt;
   logic [12:0] nib_last;
   logic [3:0]  crc_cnt;
   // First seven nibbles of the word in flight
   logic [27:0] word_sr;

   // Two nibbles per byte
   assign nib_last = {blk_size, 1'b0} - 13'd1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= DAT_IDLE;
         nib_cnt    <= '0;
         crc_cnt    <= '0;
         word_valid <= 1'b0;
         blk_done   <= 1'b0;
      end else begin
         word_valid <= 1'b0;
         blk_done   <= 1'b0;
         case (state)
            DAT_IDLE: begin
               if (dat_arm) begin
                  state <= DAT_START;
               end
            end
            DAT_START: begin
               // Bus idles at 0xF, 0x0 opens a block
               if (dat_in == 4'h0) begin
                  nib_cnt <= '0;
                  state   <= DAT_DATA;
               end
            end
            DAT_DATA: begin
               nib_cnt    <= nib_cnt + 13'd1;
               word_valid <= (nib_cnt[2:0] == 3'd7);
               if (nib_cnt == nib_last) begin
                  crc_cnt <= '0;
                  state   <= DAT_CRC;
               end
            end
            DAT_CRC: begin
               crc_cnt <= crc_cnt + 4'd1;
               if (crc_cnt == 4'(DAT_CRC_NIBBLES - 1)) begin
                  state <= DAT_END;
               end
            end
            DAT_END: begin
               // End nibble consumed
               blk_done <= 1'b1;
               state    <= dat_more ? DAT_START : DAT_IDLE;
            end
            default: state <= DAT_IDLE;
         endcase
      end
   end

   // Word assembly, MSB nibble first
   always_ff @(posedge clk) begin
      if (state == DAT_DATA) begin
         word_sr <= {word_sr[23:0], dat_in};
         if (nib_cnt[2:0] == 3'd7) begin
            word <= {word_sr, dat_in};
         end
      end
   end

   a_blk_size_ok: assert property (@(posedge clk) disable iff (!arst_n)
      dat_arm |-> (blk_size != '0) && (blk_size[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: logic/sd_cmd_phy.sv
//////////////////////////////
// CMD line driver and short response receiver
// Card line runs on clk, no clock divider
// Long responses and busy not handled
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_phy import sd_host_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     phy_start,
   input  cmd_idx_t cmd_idx,
   input  cmd_arg_t arg,
   input  logic     cmd_in,
   output logic     cmd_out,
   output logic     cmd_oe,
   output logic     resp_valid,
   output resp_t    resp
);

   cmd_state_e  state;
   // Transmission bit, index and argument still to go out
   logic [38:0] tx_sr;
   // Last 39 response bits, argument and CRC at the bottom
   logic [38:0] rx_sr;
   // Bits already on the line or already sampled
   logic [5:0]  bit_cnt;
   logic [6:0]  to_cnt;
   crc7_t       crc;

   // One serial step of x^7 + x^3 + 1
   function automatic crc7_t crc7_step(input crc7_t c, input logic b);
      logic fb;
      fb = b ^ c[6];
      return {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
   endfunction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= CMD_IDLE;
         tx_sr      <= '0;
         rx_sr      <= '0;
         bit_cnt    <= '0;
         to_cnt     <= '0;
         crc        <= '0;
         cmd_out    <= 1'b1;
         cmd_oe     <= 1'b0;
         resp_valid <= 1'b0;
         resp       <= '0;
      end else begin
         resp_valid <= 1'b0;
         case (state)
            CMD_IDLE: begin
               if (phy_start) begin
                  // Start bit goes out right away
                  cmd_out <= 1'b0;
                  cmd_oe  <= 1'b1;
                  crc     <= crc7_step('0, 1'b0);
                  tx_sr   <= {1'b1, cmd_idx, arg};
                  bit_cnt <= 6'd1;
                  state   <= CMD_SEND;
               end
            end
            //////////////////////////////
            // Frame out
            //////////////////////////////
            CMD_SEND: begin
               bit_cnt <= bit_cnt + 6'd1;
               if (bit_cnt < 6'(CMD_FRAME_BITS - 8)) begin
                  cmd_out <= tx_sr[38];
                  crc     <= crc7_step(crc, tx_sr[38]);
                  tx_sr   <= {tx_sr[37:0], 1'b0};
               end else if (bit_cnt < 6'(CMD_FRAME_BITS - 1)) begin
                  // CRC shifted out MSB first
                  cmd_out <= crc[6];
                  crc     <= {crc[5:0], 1'b0};
               end else if (bit_cnt == 6'(CMD_FRAME_BITS - 1)) begin
                  cmd_out <= 1'b1;
               end else begin
                  // End bit done, release line
                  cmd_oe  <= 1'b0;
                  cmd_out <= 1'b1;
                  to_cnt  <= '0;
                  state   <= CMD_WAIT;
               end
            end
            //////////////////////////////
            // Response in
            //////////////////////////////
            CMD_WAIT: begin
               if (!cmd_in) begin
                  crc     <= crc7_step('0, 1'b0);
                  bit_cnt <= 6'd1;
                  state   <= CMD_RECV;
               end else if (to_cnt == 7'(RESP_TIMEOUT - 1)) begin
                  resp_valid   <= 1'b1;
                  resp.arg     <= '0;
                  resp.crc_ok  <= 1'b0;
                  resp.end_ok  <= 1'b0;
                  resp.timeout <= 1'b1;
                  state        <= CMD_IDLE;
               end else begin
                  to_cnt <= to_cnt + 7'd1;
               end
            end
            CMD_RECV: begin
               bit_cnt <= bit_cnt + 6'd1;
               rx_sr   <= {rx_sr[37:0], cmd_in};
               // CRC covers start bit through argument
               if (bit_cnt < 6'(CMD_FRAME_BITS - 8)) begin
                  crc <= crc7_step(crc, cmd_in);
               end
               if (bit_cnt == 6'(CMD_FRAME_BITS - 1)) begin
                  resp_valid   <= 1'b1;
                  resp.arg     <= rx_sr[38:7];
                  resp.crc_ok  <= (rx_sr[6:0] == crc);
                  resp.end_ok  <= cmd_in;
                  resp.timeout <= 1'b0;
                  state        <= CMD_IDLE;
               end
            end
            default: state <= CMD_IDLE;
         endcase
      end
   end

   // Controller must wait for resp_valid before the next command
   a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
      phy_start |-> state == CMD_IDLE);

endmodule

`default_nettype wire

// File: logic/sd_host_regs.sv
//////////////////////////////
// Write-only register file, no readback
// Only the low half-word of each write is taken
// Command write snapshots all fields into cfg
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_host_regs import sd_host_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      req,
   input  logic      reg_wr_en,
   input  reg_addr_t reg_address,
   input  reg_data_t reg_wr_data,
   output xfer_cfg_t cfg,
   output logic      cmd_start
);

   logic        wr;
   blk_size_t   blk_size_q;
   blk_cnt_t    blk_cnt_q;
   logic [15:0] arg_lo_q;
   logic [15:0] arg_hi_q;
   logic        read_dir_q;
   logic        multi_blk_q;
   logic        blk_cnt_en_q;

   assign wr = req && reg_wr_en;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         blk_size_q   <= '0;
         blk_cnt_q    <= '0;
         arg_lo_q     <= '0;
         arg_hi_q     <= '0;
         read_dir_q   <= 1'b0;
         multi_blk_q  <= 1'b0;
         blk_cnt_en_q <= 1'b0;
         cfg          <= '0;
         cmd_start    <= 1'b0;
      end else begin
         // Strobe lasts one cycle
         cmd_start <= 1'b0;
         if (wr) begin
            case (reg_address)
               ADDR_BLK_SIZE: blk_size_q <= reg_wr_data[11:0];
               ADDR_BLK_CNT:  blk_cnt_q  <= reg_wr_data[15:0];
               ADDR_ARG_LO:   arg_lo_q   <= reg_wr_data[15:0];
               ADDR_ARG_HI:   arg_hi_q   <= reg_wr_data[15:0];
               ADDR_XFER_MODE: begin
                  // Bit 5 multi, bit 4 read, bit 1 count enable
                  multi_blk_q  <= reg_wr_data[5];
                  read_dir_q   <= reg_wr_data[4];
                  blk_cnt_en_q <= reg_wr_data[1];
               end
               ADDR_CMD: begin
                  // Freeze the whole setup for this command
                  cfg.blk_size     <= blk_size_q;
                  cfg.blk_cnt      <= blk_cnt_q;
                  cfg.arg          <= {arg_hi_q, arg_lo_q};
                  cfg.cmd_idx      <= reg_wr_data[13:8];
                  cfg.data_present <= reg_wr_data[5];
                  cfg.read_dir     <= read_dir_q;
                  cfg.multi_blk    <= multi_blk_q;
                  cfg.blk_cnt_en   <= blk_cnt_en_q;
                  cmd_start        <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   // Back-to-back command writes are not supported by the host
   a_start_single: assert property (@(posedge clk) disable iff (!arst_n)
      cmd_start |=> !cmd_start);

endmodule

`default_nettype wire

// File: logic/sd_host_pkg.sv
//////////////////////////////
// Types and constants shared by the SD host blocks
// Block size must be a nonzero multiple of 4 bytes
//////////////////////////////
`default_nettype none

package sd_host_pkg;

   // Meaningful widths
   typedef logic [11:0] reg_addr_t;
   typedef logic [31:0] reg_data_t;
   typedef logic [31:0] cmd_arg_t;
   typedef logic [5:0]  cmd_idx_t;
   typedef logic [6:0]  crc7_t;
   typedef logic [11:0] blk_size_t;
   typedef logic [15:0] blk_cnt_t;
   // First nibble received lands in bits 31:28
   typedef logic [31:0] dat_word_t;

   // Register map
   localparam reg_addr_t ADDR_BLK_SIZE  = 12'h004;
   localparam reg_addr_t ADDR_BLK_CNT   = 12'h006;
   localparam reg_addr_t ADDR_ARG_LO    = 12'h008;
   localparam reg_addr_t ADDR_ARG_HI    = 12'h00A;
   localparam reg_addr_t ADDR_XFER_MODE = 12'h00C;
   localparam reg_addr_t ADDR_CMD       = 12'h00E;

   // Line timing
   localparam int CMD_FRAME_BITS  = 48;
   localparam int RESP_TIMEOUT    = 64;
   localparam int DAT_CRC_NIBBLES = 16;

   typedef struct packed {
      blk_size_t blk_size;
      blk_cnt_t  blk_cnt;
      cmd_arg_t  arg;
      cmd_idx_t  cmd_idx;
      logic      data_present;
      logic      read_dir;
      logic      multi_blk;
      logic      blk_cnt_en;
   } xfer_cfg_t;

   typedef struct packed {
      cmd_arg_t arg;
      logic     crc_ok;
      logic     end_ok;
      logic     timeout;
   } resp_t;

   typedef struct packed {
      logic     resp_err;
      logic     timeout;
      blk_cnt_t blocks_done;
   } xfer_status_t;

   typedef enum logic [1:0] {CMD_IDLE, CMD_SEND, CMD_WAIT, CMD_RECV} cmd_state_e;
   typedef enum logic [2:0] {DAT_IDLE, DAT_START, DAT_DATA, DAT_CRC, DAT_END} dat_state_e;
   typedef enum logic [1:0] {CTRL_IDLE, CTRL_CMD, CTRL_DATA} ctrl_state_e;

endpackage

`default_nettype wire
